// File: include/ieu_macros.svh
// Width and register-file size defines, included by every RTL file that sizes a bus
`ifndef IEU_MACROS_SVH
`define IEU_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////////////////////

// Integer register and ALU width
`define XLEN 32

// Register index width for x0..x31
`define REG_ADDR_W 5

// Number of architectural integer registers
`define NREGS 32

`endif

// File: logic/ieu_pkg.sv
// Shared types and encodings of the integer pipeline; imported by decoder, ALU and datapath
`include "ieu_macros.svh"

package ieu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and immediate encodings
  ////////////////////////////////////////////////////////////////////////////

  // ALU function select with PASSB handing the immediate through for LUI
  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluXor,
    aluSlt,                                     // Signed less than
    aluSltu,                                    // Unsigned less than
    aluSll,
    aluSrl,
    aluSra,
    aluPassB
  } aluOpT;

  // Immediate format of the decoded instruction
  typedef enum logic [1:0] {
    immI,                                       // Sign-extended imm[11:0]
    immShift,                                   // Shamt in imm[4:0], zero-extended
    immU                                        // imm[31:12] << 12
  } immSrcT;

  // Execute-stage control word, carried down the pipe by stageReg
  typedef struct packed {
    aluOpT                  aluOp;
    logic                   srcBImm;            // Operand B is the immediate
    logic                   valid;              // Stage holds a real instruction
    logic                   regWrite;           // Result goes to the register file
    logic [`REG_ADDR_W-1:0] rd;                 // Destination index
  } ctrlET;

  // Major opcodes of the supported subset
  localparam logic [6:0] opImm = 7'b0010011;   // ADDI, SLTI, ... SRAI
  localparam logic [6:0] opReg = 7'b0110011;   // R-type ALU
  localparam logic [6:0] opLui = 7'b0110111;

  // Operand bypass select
  localparam logic [1:0] fwdRf = 2'b00;        // Register file value
  localparam logic [1:0] fwdW  = 2'b01;        // Writeback result
  localparam logic [1:0] fwdM  = 2'b10;        // Memory stage result

endpackage

// File: logic/stageReg.sv
// Generic pipeline register; one instance per payload (control word, data, indices)
`timescale 1ns/1ps

module stageReg #(
  parameter type payloadT = logic
) (
  input  logic    clk, rst,
  input  logic    en,                            // Low holds the stage
  input  payloadT d,
  output payloadT q
);

  // Clears to zero, which also makes an invalid control word
  always_ff @(posedge clk) begin
    if (rst)     q <= '0;
    else if (en) q <= d;
  end

endmodule

// File: logic/decoder.sv
// Instruction decoder; turns one RV32I ALU instruction into control, indices and an immediate
`timescale 1ns/1ps
`include "ieu_macros.svh"

module decoder (
  input  logic [31:0]             instr,
  output logic [`REG_ADDR_W-1:0]  rs1, rs2, rd,     // Register indices
  output logic [`XLEN-1:0]        immExt,           // Extended immediate
  output ieu_pkg::aluOpT          aluOp,
  output logic                    srcBImm,          // B operand from immediate
  output logic                    regWrite,
  output logic                    legal             // Supported encoding
);
  import ieu_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  immSrcT     immSrc;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  ////////////////////////////////////////////////////////////////////////////
  // Main decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    aluOp   = aluAdd;                            // Defaults describe a bubble
    srcBImm = 1'b0;
    immSrc  = immI;
    legal   = 1'b0;
    case (opcode)
      opReg: begin
        // Only SUB and SRA may set funct7[5]
        legal = (funct7 == 7'b0000000) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        case (funct3)
          3'b000:  aluOp = funct7[5] ? aluSub : aluAdd;
          3'b001:  aluOp = aluSll;
          3'b010:  aluOp = aluSlt;
          3'b011:  aluOp = aluSltu;
          3'b100:  aluOp = aluXor;
          3'b101:  aluOp = funct7[5] ? aluSra : aluSrl;
          3'b110:  aluOp = aluOr;
          default: aluOp = aluAnd;
        endcase
      end
      opImm: begin
        srcBImm = 1'b1;
        legal   = 1'b1;
        case (funct3)
          3'b000:  aluOp = aluAdd;              // No SUBI in the ISA
          3'b010:  aluOp = aluSlt;
          3'b011:  aluOp = aluSltu;
          3'b100:  aluOp = aluXor;
          3'b110:  aluOp = aluOr;
          3'b111:  aluOp = aluAnd;
          3'b001: begin
            aluOp  = aluSll;
            immSrc = immShift;
            legal  = (funct7 == 7'b0000000);
          end
          default: begin                        // SRLI / SRAI
            aluOp  = funct7[5] ? aluSra : aluSrl;
            immSrc = immShift;
            legal  = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
          end
        endcase
      end
      opLui: begin
        aluOp   = aluPassB;
        srcBImm = 1'b1;
        immSrc  = immU;
        legal   = 1'b1;
      end
      default: legal = 1'b0;                   // Loads, branches, system etc
    endcase
  end

  // Unused source fields are forced to x0 so no bypass fires on them
  assign rs1      = (opcode == opLui) ? '0 : instr[19:15];
  assign rs2      = srcBImm ? '0 : instr[24:20];
  assign rd       = instr[11:7];
  assign regWrite = legal;

  // Immediate extension
  always_comb begin
    case (immSrc)
      immI:     immExt = `XLEN'(signed'(instr[31:20]));
      immShift: immExt = `XLEN'(instr[24:20]);
      immU:     immExt = `XLEN'(signed'({instr[31:12], 12'b0}));
      default:  immExt = '0;
    endcase
  end

endmodule

// File: logic/regFile.sv
// Two-read one-write integer register file with x0 at zero and write-through reads
`timescale 1ns/1ps
`include "ieu_macros.svh"

module regFile (
  input  logic                   clk, rst,
  input  logic                   we,                // Write enable from Writeback
  input  logic [`REG_ADDR_W-1:0] ra1, ra2, wa,
  input  logic [`XLEN-1:0]       wd,
  output logic [`XLEN-1:0]       rd1, rd2
);

  logic [`XLEN-1:0] regs [`NREGS];

  // Whole array cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NREGS; i++) regs[i] <= '0;
    end else if (we && wa != '0) begin          // Writes to x0 dropped
      regs[wa] <= wd;
    end
  end

  // x0 reads zero and a same-cycle write is bypassed to the read port
  always_comb begin
    if (ra1 == '0)              rd1 = '0;
    else if (we && wa == ra1)   rd1 = wd;
    else                        rd1 = regs[ra1];
  end

  always_comb begin
    if (ra2 == '0)              rd2 = '0;
    else if (we && wa == ra2)   rd2 = wd;
    else                        rd2 = regs[ra2];
  end

endmodule

// File: logic/forwardUnit.sv
// Hazard bypass select for the two Execute operands; Memory results win over Writeback
`timescale 1ns/1ps
`include "ieu_macros.svh"

module forwardUnit (
  input  logic [`REG_ADDR_W-1:0] rs1E, rs2E,       // Execute sources
  input  logic [`REG_ADDR_W-1:0] rdM, rdW,         // Producer destinations
  input  logic                   regWriteM, regWriteW,
  output logic [1:0]             forwardA, forwardB
);
  import ieu_pkg::*;

  // Youngest producer wins and x0 is never a producer
  function automatic logic [1:0] pickSrc(input logic [`REG_ADDR_W-1:0] rs);
    logic [1:0] sel;
    sel = fwdRf;
    if (rs != '0) begin
      if (regWriteM && rdM == rs)      sel = fwdM;
      else if (regWriteW && rdW == rs) sel = fwdW;
    end
    return sel;
  endfunction

  assign forwardA = pickSrc(rs1E);
  assign forwardB = pickSrc(rs2E);               // rs2E is x0 for immediate forms

endmodule

// File: logic/alu.sv
// Integer ALU of the Execute stage; add/sub, logic, compares, shifts and pass-B for LUI
`timescale 1ns/1ps
`include "ieu_macros.svh"

module alu (
  input  logic [`XLEN-1:0] a, b,
  input  ieu_pkg::aluOpT   aluOp,
  output logic [`XLEN-1:0] result
);
  import ieu_pkg::*;

  localparam int shamtW = $clog2(`XLEN);

  logic [shamtW-1:0] shamt;
  logic [`XLEN-1:0]  sum, diff;
  logic              ltSigned, ltUnsigned;

  assign shamt = b[shamtW-1:0];                  // Low 5 bits only

  ////////////////////////////////////////////////////////////////////////////
  // Arithmetic and compare
  ////////////////////////////////////////////////////////////////////////////

  assign sum  = a + b;
  assign diff = a - b;

  assign ltSigned   = $signed(a) < $signed(b);
  assign ltUnsigned = a < b;

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (aluOp)
      aluAdd:   result = sum;
      aluSub:   result = diff;
      aluAnd:   result = a & b;
      aluOr:    result = a | b;
      aluXor:   result = a ^ b;
      aluSlt:   result = `XLEN'(ltSigned);
      aluSltu:  result = `XLEN'(ltUnsigned);
      aluSll:   result = a << shamt;
      aluSrl:   result = a >> shamt;
      aluSra:   result = $unsigned($signed(a) >>> shamt);
      aluPassB: result = b;                       // LUI immediate
      default:  result = '0;
    endcase
  end

endmodule

// File: logic/datapath.sv
// Execute, Memory and Writeback stages with pipe registers, operand bypass and the ALU
`timescale 1ns/1ps
`include "ieu_macros.svh"

module datapath (
  input  logic                   clk, rst,
  input  logic                   stall,            // Freezes every stage
  input  logic                   validD,           // Decode holds an accepted instruction
  input  ieu_pkg::ctrlET         ctrlD,
  input  logic [`REG_ADDR_W-1:0] rs1D, rs2D,
  input  logic [`XLEN-1:0]       R1D, R2D,         // Register file read data
  input  logic [`XLEN-1:0]       immExtD,
  input  logic [1:0]             forwardA, forwardB,
  output logic [`REG_ADDR_W-1:0] rs1E, rs2E,
  output logic [`REG_ADDR_W-1:0] rdM, rdW,
  output logic                   regWriteM,
  output logic                   regWriteW,        // Also the register file write enable
  output logic [`XLEN-1:0]       resultW,
  output logic                   wbValid
);
  import ieu_pkg::*;

  logic             stageEn;
  ctrlET            ctrlIn, ctrlE, ctrlM, ctrlW;
  logic [`XLEN-1:0] R1E, R2E, immExtE;
  logic [`XLEN-1:0] srcAE, fwdBE, srcBE;
  logic [`XLEN-1:0] aluResultE, resultM;

  assign stageEn = ~stall;

  // Rejected or illegal slots enter Execute as all-zero bubbles
  assign ctrlIn = validD ? ctrlD : '0;

  ////////////////////////////////////////////////////////////////////////////
  // D/E register
  ////////////////////////////////////////////////////////////////////////////

  stageReg #(.payloadT(ctrlET)) ctrlEReg (
    .clk, .rst, .en(stageEn), .d(ctrlIn), .q(ctrlE));
  stageReg #(.payloadT(logic [`XLEN-1:0])) r1EReg (
    .clk, .rst, .en(stageEn), .d(R1D), .q(R1E));
  stageReg #(.payloadT(logic [`XLEN-1:0])) r2EReg (
    .clk, .rst, .en(stageEn), .d(R2D), .q(R2E));
  stageReg #(.payloadT(logic [`XLEN-1:0])) immEReg (
    .clk, .rst, .en(stageEn), .d(immExtD), .q(immExtE));
  stageReg #(.payloadT(logic [`REG_ADDR_W-1:0])) rs1EReg (
    .clk, .rst, .en(stageEn), .d(rs1D), .q(rs1E));
  stageReg #(.payloadT(logic [`REG_ADDR_W-1:0])) rs2EReg (
    .clk, .rst, .en(stageEn), .d(rs2D), .q(rs2E));

  ////////////////////////////////////////////////////////////////////////////
  // Execute
  ////////////////////////////////////////////////////////////////////////////

  // Operand bypass muxes
  always_comb begin
    case (forwardA)
      fwdM:    srcAE = resultM;                  // Distance 1
      fwdW:    srcAE = resultW;                  // Distance 2
      default: srcAE = R1E;
    endcase
    case (forwardB)
      fwdM:    fwdBE = resultM;
      fwdW:    fwdBE = resultW;
      default: fwdBE = R2E;
    endcase
  end

  assign srcBE = ctrlE.srcBImm ? immExtE : fwdBE; // Immediate forms and LUI

  alu aluE (.a(srcAE), .b(srcBE), .aluOp(ctrlE.aluOp), .result(aluResultE));

  ////////////////////////////////////////////////////////////////////////////
  // E/M and M/W registers
  ////////////////////////////////////////////////////////////////////////////

  stageReg #(.payloadT(ctrlET)) ctrlMReg (
    .clk, .rst, .en(stageEn), .d(ctrlE), .q(ctrlM));
  stageReg #(.payloadT(logic [`XLEN-1:0])) resultMReg (
    .clk, .rst, .en(stageEn), .d(aluResultE), .q(resultM));

  // No load unit in Memory so the ALU result goes straight on
  stageReg #(.payloadT(ctrlET)) ctrlWReg (
    .clk, .rst, .en(stageEn), .d(ctrlM), .q(ctrlW));
  stageReg #(.payloadT(logic [`XLEN-1:0])) resultWReg (
    .clk, .rst, .en(stageEn), .d(resultM), .q(resultW));

  ////////////////////////////////////////////////////////////////////////////
  // Producer info and Writeback
  ////////////////////////////////////////////////////////////////////////////

  assign rdM       = ctrlM.rd;
  assign regWriteM = ctrlM.regWrite;             // Already qualified by valid
  assign rdW       = ctrlW.rd;

  // A held Writeback neither writes nor reports, so each result appears once
  assign regWriteW = ctrlW.regWrite & ~stall;
  assign wbValid   = ctrlW.valid & ~stall;

endmodule

// File: logic/ieuTop.sv
// Top of the integer pipeline; wires decoder, register file, bypass logic and datapath
`timescale 1ns/1ps
`include "ieu_macros.svh"

module ieuTop (
  input  logic                   clk, rst,
  input  logic [31:0]            instr,
  input  logic                   instrValid,
  input  logic                   stall,            // Global back-pressure
  output logic                   wbValid,
  output logic [`REG_ADDR_W-1:0] wbRd,
  output logic [`XLEN-1:0]       wbData
);
  import ieu_pkg::*;

  logic [`REG_ADDR_W-1:0] rs1D, rs2D, rdD;
  logic [`REG_ADDR_W-1:0] rs1E, rs2E, rdM, rdW;
  logic [`XLEN-1:0]       immExtD, R1D, R2D, resultW;
  aluOpT                  aluOpD;
  logic                   srcBImmD, regWriteD, legalD, validD;
  logic                   regWriteM, regWriteW;
  logic [1:0]             forwardA, forwardB;
  ctrlET                  ctrlD;

  ////////////////////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////////////////////

  decoder dec (
    .instr, .rs1(rs1D), .rs2(rs2D), .rd(rdD), .immExt(immExtD),
    .aluOp(aluOpD), .srcBImm(srcBImmD), .regWrite(regWriteD), .legal(legalD));

  regFile rf (
    .clk, .rst, .we(regWriteW), .ra1(rs1D), .ra2(rs2D), .wa(rdW),
    .wd(resultW), .rd1(R1D), .rd2(R2D));

  assign validD = instrValid & legalD;           // Illegal opcodes become bubbles

  // Decoded control word that the datapath zeroes for a bubble
  assign ctrlD = '{aluOp: aluOpD, srcBImm: srcBImmD, valid: legalD,
                   regWrite: regWriteD, rd: rdD};

  ////////////////////////////////////////////////////////////////////////////
  // Execute through Writeback
  ////////////////////////////////////////////////////////////////////////////

  forwardUnit fwd (
    .rs1E, .rs2E, .rdM, .rdW, .regWriteM, .regWriteW, .forwardA, .forwardB);

  datapath dp (
    .clk, .rst, .stall, .validD, .ctrlD, .rs1D, .rs2D, .R1D, .R2D, .immExtD,
    .forwardA, .forwardB, .rs1E, .rs2E, .rdM, .rdW, .regWriteM, .regWriteW,
    .resultW, .wbValid);

  assign wbRd   = rdW;
  assign wbData = resultW;                       // Reported even for rd = x0

endmodule

// File: testbench/ieu_chk.sv
// Concurrent protocol assertions, bound into ieuTop from the testbench
`timescale 1ns/1ps
`include "ieu_macros.svh"

module ieu_chk (
  input logic                   clk, rst,
  input logic                   stall,
  input logic                   wbValid,
  input logic [`XLEN-1:0]       wbData,
  input logic [1:0]             forwardA, forwardB,
  input logic [`REG_ADDR_W-1:0] rs1E, rs2E
);
  import ieu_pkg::*;

  // A frozen or resetting pipe reports nothing
  noWbInStall: assert property (@(posedge clk) (stall || rst) |-> (wbValid !== 1'b1))
    else $error("wbValid high during stall or reset");

  // Reported data is fully known
  wbDataKnown: assert property (@(posedge clk) disable iff (rst)
    wbValid |-> !$isunknown(wbData))
    else $error("wbData holds X or Z while wbValid is high");

  // x0 never feeds a bypass
  noFwdFromX0A: assert property (@(posedge clk) disable iff (rst)
    (forwardA != fwdRf) |-> (rs1E != '0))
    else $error("operand A bypass selected for source x0");

  noFwdFromX0B: assert property (@(posedge clk) disable iff (rst)
    (forwardB != fwdRf) |-> (rs2E != '0))
    else $error("operand B bypass selected for source x0");

endmodule

bind ieuTop ieu_chk chk (
  .clk, .rst, .stall, .wbValid, .wbData, .forwardA, .forwardB, .rs1E, .rs2E);

// File: testbench/clockGen.sv
// Testbench clock and reset source; 20 ns clock, reset held high for the first 10 cycles
`timescale 1ns/1ps

module clockGen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;                                  // Reset asserted from time zero
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  end

  always #10 clk = ~clk;                         // Half of the 20 ns period

endmodule

// File: testbench/ieuTb.sv
// Top testbench of the integer pipeline; directed, dependency, random and illegal-opcode runs
`timescale 1ns/1ps
`include "ieu_macros.svh"

module ieuTb;
  import ieu_pkg::*;

  logic                   clk, rst;
  logic [31:0]            instr;
  logic                   instrValid, stall;
  logic                   wbValid;
  logic [`REG_ADDR_W-1:0] wbRd;
  logic [`XLEN-1:0]       wbData;

  logic [15:0]            lfsr = 16'd5;          // Seed
  logic [`XLEN-1:0]       model [`NREGS];        // Reference register file
  logic [`REG_ADDR_W-1:0] expRd [$];
  logic [`XLEN-1:0]       expData [$];
  int                     expCycle [$];
  bit                     expStrict [$];         // Latency checked for this entry
  bit                     strictPhase;
  int                     cycle;
  string                  testName;

  clockGen clkGen (.clk, .rst);

  ieuTop UUT (.clk, .rst, .instr, .instrValid, .stall, .wbValid, .wbRd, .wbData);

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // Taps 16 14 13 11
  endfunction

  task automatic nextBits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opReg};
  endfunction

  function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opImm};
  endfunction

  function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opLui};
  endfunction

  // RV32I semantics on the model registers
  // Returns 0 for an unsupported encoding
  function automatic bit refExec(input logic [31:0] ins, output logic [4:0] rd,
                                 output logic [`XLEN-1:0] val);
    logic [`XLEN-1:0] a, b;
    logic [2:0]       f3;
    logic [6:0]       f7;
    bit               isReg;
    f3    = ins[14:12];
    f7    = ins[31:25];
    rd    = ins[11:7];
    a     = (ins[19:15] == 0) ? '0 : model[ins[19:15]];
    isReg = (ins[6:0] == opReg);
    val   = '0;
    if (ins[6:0] == opLui) begin
      val = {ins[31:12], 12'b0};
      return 1;
    end
    if (!isReg && ins[6:0] != opImm) return 0;
    if (isReg && !(f7 == 0 || (f7 == 7'h20 && (f3 == 0 || f3 == 5)))) return 0;
    if (!isReg && f3 == 1 && f7 != 0) return 0;
    if (!isReg && f3 == 5 && !(f7 == 0 || f7 == 7'h20)) return 0;
    b = isReg ? ((ins[24:20] == 0) ? '0 : model[ins[24:20]]) : {{20{ins[31]}}, ins[31:20]};
    case (f3)
      0: val = (isReg && f7[5]) ? a - b : a + b;
      1: val = a << b[4:0];
      2: val = {31'b0, $signed(a) < $signed(b)};
      3: val = {31'b0, a < b};
      4: val = a ^ b;
      5: val = f7[5] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      6: val = a | b;
      default: val = a & b;
    endcase
    return 1;
  endfunction

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic checkData(input string name, input logic [`XLEN-1:0] exp, act);
    if (act !== exp) begin
      $display("mismatch %s data expected %h actual %h", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkIdx(input string name, input logic [`REG_ADDR_W-1:0] exp, act);
    if (act !== exp) begin
      $display("mismatch %s rd expected %0d actual %0d", name, exp, act);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic drive(input logic [31:0] ins, input logic v, s);
    @(posedge clk);
    instr      <= ins;
    instrValid <= v;
    stall      <= s;
  endtask

  task automatic idle(input int n);
    repeat (n) drive('0, 1'b0, 1'b0);
  endtask

  // Holds one instruction until a non-stalled cycle takes it
  task automatic issue(input logic [31:0] ins, input bit randStall);
    logic [31:0] r;
    int          tries;
    tries = 0;
    r     = '0;
    do begin
      if (randStall) nextBits(2, r);
      drive(ins, 1'b1, randStall && (r[1:0] == 0) && tries < 20);
      tries++;
    end while ((r[1:0] == 0) && tries <= 20 && randStall);
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (expRd.size() != 0 && n < 40) begin
      idle(1);
      n++;
    end
    if (expRd.size() != 0) fail("timeout waiting for pending writebacks");
  endtask

  task automatic randInstr(output logic [31:0] ins);
    logic [31:0] k, f3, r1, r2, rd, imm, bit5;
    nextBits(2, k);
    nextBits(3, f3);
    nextBits(3, r1);
    nextBits(3, r2);
    nextBits(3, rd);
    nextBits(1, bit5);
    if (k == 2) begin
      nextBits(20, imm);
      ins = uType(imm[19:0], rd[4:0]);
    end else if (k == 3) begin
      ins = rType((bit5[0] && (f3 == 0 || f3 == 5)) ? 7'h20 : 7'h00,
                  r2[4:0], r1[4:0], f3[2:0], rd[4:0]);
    end else begin
      nextBits(12, imm);
      if (f3 == 1) imm = {7'b0, imm[4:0]};
      if (f3 == 5) imm = {1'b0, bit5[0], 5'b0, imm[4:0]};
      ins = iType(imm[11:0], r1[4:0], f3[2:0], rd[4:0]);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Reference and compare processes
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) cycle <= cycle + 1;

  // Inputs are stable at the falling edge and taken at the next rise
  always @(negedge clk) begin
    logic [4:0]       rd;
    logic [`XLEN-1:0] val;
    if (!rst && instrValid && !stall) begin
      if (refExec(instr, rd, val)) begin
        if (rd != 0) model[rd] = val;
        expRd.push_back(rd);
        expData.push_back(val);
        expCycle.push_back(cycle);
        expStrict.push_back(strictPhase);
      end
    end
  end

  always @(negedge clk) begin
    int  c;
    bit  s;
    if (!rst && wbValid) begin
      if (expRd.size() == 0) fail($sformatf("%s: writeback with no pending result", testName));
      c = expCycle.pop_front();
      s = expStrict.pop_front();
      checkIdx(testName, expRd.pop_front(), wbRd);
      checkData(testName, expData.pop_front(), wbData);
      if (s && cycle != c + 3)
        fail($sformatf("%s: result came %0d cycles after acceptance", testName, cycle - c));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Phases
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] ins, gap;
    int          n;
    for (int i = 0; i < `NREGS; i++) model[i] = '0;
    cycle       = 0;
    strictPhase = 1'b1;
    testName    = "reset";
    instr      <= '0;
    instrValid <= 1'b0;
    stall      <= 1'b0;
    n = 0;
    while (rst !== 1'b0 && n < 50) begin
      @(posedge clk);
      n++;
    end
    if (rst !== 1'b0) fail("timeout waiting for reset release");
    idle(4);                                     // No writeback may appear here

    testName = "aluOps";
    issue(uType(20'h80000, 1), 0);               // LUI
    issue(iType(12'h123, 1, 0, 1), 0);
    issue(iType(12'hffb, 0, 0, 2), 0);           // x2 = -5
    issue(rType(7'h00, 2, 1, 0, 3), 0);
    issue(rType(7'h20, 2, 1, 0, 4), 0);
    for (int f = 1; f < 8; f++) issue(rType(7'h00, 2, 1, f[2:0], 5), 0);
    issue(rType(7'h20, 2, 1, 5, 6), 0);          // SRA
    issue(iType(12'h004, 1, 1, 7), 0);           // SLLI
    issue(iType(12'h008, 1, 5, 7), 0);           // SRLI
    issue(iType(12'h408, 1, 5, 7), 0);           // SRAI
    for (int f = 2; f < 8; f++) if (f != 5) issue(iType(12'h8f0, 2, f[2:0], 8), 0);
    issue(iType(12'h005, 1, 0, 0), 0);           // Nonzero write to x0 is dropped
    issue(rType(7'h00, 0, 0, 0, 9), 0);
    drain();

    testName = "forwarding";
    issue(iType(12'h001, 0, 0, 7), 0);
    issue(iType(12'h001, 7, 0, 7), 0);           // Distance 1
    issue(iType(12'h003, 0, 0, 8), 0);
    issue(iType(12'h002, 7, 0, 7), 0);           // Distance 2
    issue(iType(12'h001, 0, 0, 12), 0);
    issue(iType(12'h002, 0, 0, 13), 0);
    issue(rType(7'h00, 8, 7, 0, 11), 0);         // Distance 3 through write-through
    issue(iType(12'h009, 0, 0, 14), 0);
    idle(1);
    issue(rType(7'h00, 14, 14, 0, 15), 0);
    drain();

    testName    = "random";
    strictPhase = 1'b0;
    for (int i = 0; i < 300; i++) begin
      nextBits(2, gap);
      if (gap == 0) begin
        nextBits(1, gap);
        drive('0, 1'b0, gap[0]);
      end
      randInstr(ins);
      issue(ins, 1);
    end
    idle(1);
    drain();

    testName    = "illegal";
    strictPhase = 1'b1;
    issue(32'h0000_2083, 0);                     // LW
    issue(iType(12'h011, 0, 0, 3), 0);
    issue(32'h0000_0063, 0);                     // BEQ
    issue(rType(7'h01, 3, 3, 0, 4), 0);          // MUL encoding
    issue(iType(12'h401, 3, 1, 5), 0);           // SLLI with bad funct7
    issue(rType(7'h00, 3, 3, 0, 6), 0);
    drain();
    idle(5);

    if (expRd.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule

// File: vlog.f
+incdir+include
logic/ieu_pkg.sv
logic/stageReg.sv
logic/decoder.sv
logic/regFile.sv
logic/forwardUnit.sv
logic/alu.sv
logic/datapath.sv
logic/ieuTop.sv
testbench/ieu_chk.sv
testbench/clockGen.sv
testbench/ieuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator, run it and check for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module ieuTb -o simv

out=$(./obj_dir/simv 2>&1) || true
echo "$out"

if grep -q "TEST PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi
